// ==== common/mmio_defs.svh ====
// Width, register count and address window macros for the MMIO register block
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// Width of one register line in bits
`define MMIO_DATA_WIDTH 64

// Number of control registers in the block
`define MMIO_NUM_REGS 16

// Register index width, enough to select one of MMIO_NUM_REGS
`define MMIO_REG_IDX_BITS 4

// Size of the byte-addressed register window
// Each register takes one qword, so this is MMIO_NUM_REGS * 8
`define MMIO_WINDOW_BYTES 128

// Legal write sizes in bytes
`define MMIO_DWORD_BYTES 4
`define MMIO_QWORD_BYTES 8

`endif

// ==== common/mmio_pkg.sv ====
// Package with the vector types shared by the MMIO write and read-back path
`include "mmio_defs.svh"

package mmio_pkg;

    // Host byte address as carried by the request
    // Only the low bits select a register, the rest are range checked
    typedef logic [63:0] t_byte_addr;

    // Write payload length in bytes
    typedef logic [11:0] t_byte_count;

    // One register line of data
    typedef logic [`MMIO_DATA_WIDTH-1:0] t_payload;

    // Byte enables, one bit per byte of a register line
    typedef logic [`MMIO_DATA_WIDTH/8-1:0] t_byte_mask;

    // Index of a register in the file
    typedef logic [`MMIO_REG_IDX_BITS-1:0] t_reg_idx;

endpackage

// ==== rtl/mmio_wr_decode.sv ====
// Write request decode stage with size, alignment and range checks
`timescale 1ns/1ps
`include "mmio_defs.svh"

module mmio_wr_decode
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Host write request, valid for one cycle when wr_req is high
    input  logic                    wr_req,
    input  mmio_pkg::t_byte_addr    wr_addr,
    input  mmio_pkg::t_byte_count   wr_count,
    input  mmio_pkg::t_payload      wr_data,

    // Registered request, one cycle after it was sampled
    output logic                    dec_valid,
    output logic                    dec_err,
    output mmio_pkg::t_reg_idx      dec_idx,
    output mmio_pkg::t_byte_addr    dec_addr,
    output mmio_pkg::t_byte_count   dec_count,
    output mmio_pkg::t_payload      dec_data
);

    logic is_dword;
    logic is_qword;
    logic bad_size;
    logic bad_align;
    logic out_of_window;
    logic req_err;

    // Only 4 and 8 byte writes are supported
    assign is_dword = (wr_count == mmio_pkg::t_byte_count'(`MMIO_DWORD_BYTES));
    assign is_qword = (wr_count == mmio_pkg::t_byte_count'(`MMIO_QWORD_BYTES));
    assign bad_size = !(is_dword || is_qword);

    // Every write must be dword aligned, and a qword write must sit on a qword
    assign bad_align = (wr_addr[1:0] != 2'b00) || (is_qword && wr_addr[2]);

    // The full 64-bit address is compared so high address bits are not aliased
    assign out_of_window = (wr_addr >= mmio_pkg::t_byte_addr'(`MMIO_WINDOW_BYTES));

    assign req_err = bad_size || bad_align || out_of_window;

    // Control flags of the stage
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dec_valid <= 1'b0;
            dec_err   <= 1'b0;
        end
        else
        begin
            // A strobe in gives a strobe out, so dec_valid lasts one cycle
            dec_valid <= wr_req;
            dec_err   <= wr_req && req_err;
        end
    end

    // Request fields, captured only when a request arrives
    always_ff @(posedge clk)
    begin
        if (wr_req)
        begin
            // Each register is one qword, so the index starts at address bit 3
            dec_idx   <= wr_addr[3 +: `MMIO_REG_IDX_BITS];
            dec_addr  <= wr_addr;
            dec_count <= wr_count;
            dec_data  <= wr_data;
        end
    end

endmodule

// ==== mmio_wr_data/mmio_wr_data_map.sv ====
// Write payload replication and dword-granular byte mask generation
`timescale 1ns/1ps

module mmio_wr_data_map
#(
    // Any multiple of 32 up to 512
    parameter int DATA_WIDTH = 64
)
(
    // Only the low address bits matter here, they place the data in the line
    input  mmio_pkg::t_byte_addr    byte_addr,
    input  mmio_pkg::t_byte_count   byte_count,
    input  logic [DATA_WIDTH-1:0]   payload_in,

    output logic [DATA_WIDTH-1:0]   payload_out,
    output logic [DATA_WIDTH/8-1:0] byte_mask
);

    localparam int NUM_DWORDS   = DATA_WIDTH / 32;
    localparam int DW_IDX_BITS  = $clog2(NUM_DWORDS);

    // Copy the low chunk of a 512-bit line into every chunk of the same size
    // Narrower lines take the low part of the result
    function automatic logic [511:0] fill_line(
        input mmio_pkg::t_byte_count n_bytes,
        input logic [511:0]          line_in
    );
        logic [511:0] line_out;

        if (n_bytes <= 4)
            line_out = {16{line_in[31:0]}};
        else if (n_bytes <= 8)
            line_out = {8{line_in[63:0]}};
        else if (n_bytes <= 16)
            line_out = {4{line_in[127:0]}};
        else if (n_bytes <= 32)
            line_out = {2{line_in[255:0]}};
        else
            line_out = line_in;
        return line_out;
    endfunction

    logic [511:0]            wide_in;
    logic [511:0]            wide_out;
    logic [NUM_DWORDS-1:0]   dw_count_mask;
    logic [NUM_DWORDS-1:0]   dw_mask;

    // Zero-extend the payload to the widest supported line
    assign wide_in     = 512'(payload_in);
    assign wide_out    = fill_line(byte_count, wide_in);
    assign payload_out = wide_out[DATA_WIDTH-1:0];

    // One bit per dword covered by the write, starting at dword 0
    assign dw_count_mask = ~(~NUM_DWORDS'(0) << byte_count[2 +: DW_IDX_BITS+1]);

    // Move the run of dwords to the dword offset of the address
    assign dw_mask = dw_count_mask << byte_addr[2 +: DW_IDX_BITS];

    // Each dword enable turns into four byte enables
    always_comb
    begin
        for (int dw = 0; dw < NUM_DWORDS; dw++)
        begin
            byte_mask[dw*4 +: 4] = {4{dw_mask[dw]}};
        end
    end

endmodule

// ==== mmio_csr_file/mmio_csr_file.sv ====
// Control register array with byte-masked writes, write outcome pulses and registered reads
`timescale 1ns/1ps
`include "mmio_defs.svh"

module mmio_csr_file
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Decoded write and its mapped data
    input  logic                    dec_valid,
    input  logic                    dec_err,
    input  mmio_pkg::t_reg_idx      dec_idx,
    input  mmio_pkg::t_payload      map_data,
    input  mmio_pkg::t_byte_mask    map_mask,

    // Read request, one-cycle strobe
    input  logic                    rd_req,
    input  mmio_pkg::t_reg_idx      rd_idx,

    // Write outcome, one of the two pulses per decoded write
    output logic                    wr_ack,
    output logic                    wr_err,

    // Read response, one cycle after the request
    output logic                    rd_valid,
    output mmio_pkg::t_payload      rd_data
);

    localparam int NUM_BYTES = $bits(mmio_pkg::t_byte_mask);

    mmio_pkg::t_payload regs [`MMIO_NUM_REGS];

    logic commit;

    // Decode already flagged illegal requests, so only the flag is consulted
    assign commit = dec_valid && !dec_err;

    // Register contents and outcome pulses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < `MMIO_NUM_REGS; r++)
            begin
                regs[r] <= '0;
            end
            wr_ack <= 1'b0;
            wr_err <= 1'b0;
        end
        else
        begin
            if (commit)
            begin
                // Bytes outside the mask keep their value
                for (int b = 0; b < NUM_BYTES; b++)
                begin
                    if (map_mask[b])
                        regs[dec_idx][b*8 +: 8] <= map_data[b*8 +: 8];
                end
            end
            wr_ack <= commit;
            wr_err <= dec_valid && dec_err;
        end
    end

    // Read strobe, delayed to match the data
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_valid <= 1'b0;
        else
            rd_valid <= rd_req;
    end

    // The array is sampled before a same-edge commit lands, giving the old value
    always_ff @(posedge clk)
    begin
        if (rd_req)
            rd_data <= regs[rd_idx];
    end

endmodule

// ==== rtl/mmio_wr_top.sv ====
// Top level of the MMIO write and read-back path
`timescale 1ns/1ps
`include "mmio_defs.svh"

module mmio_wr_top
(
    input  logic                    clk,
    input  logic                    rst_n,

    // Host write request
    input  logic                    wr_req,
    input  mmio_pkg::t_byte_addr    wr_addr,
    input  mmio_pkg::t_byte_count   wr_count,
    input  mmio_pkg::t_payload      wr_data,

    // Host read request
    input  logic                    rd_req,
    input  mmio_pkg::t_reg_idx      rd_idx,

    // Write outcome and read response
    output logic                    wr_ack,
    output logic                    wr_err,
    output logic                    rd_valid,
    output mmio_pkg::t_payload      rd_data
);

    // Decode stage outputs
    logic                   dec_valid;
    logic                   dec_err;
    mmio_pkg::t_reg_idx     dec_idx;
    mmio_pkg::t_byte_addr   dec_addr;
    mmio_pkg::t_byte_count  dec_count;
    mmio_pkg::t_payload     dec_data;

    // Line-aligned data and byte enables for the register file
    mmio_pkg::t_payload     map_data;
    mmio_pkg::t_byte_mask   map_mask;

    mmio_wr_decode u_decode
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_count  (wr_count),
        .wr_data   (wr_data),
        .dec_valid (dec_valid),
        .dec_err   (dec_err),
        .dec_idx   (dec_idx),
        .dec_addr  (dec_addr),
        .dec_count (dec_count),
        .dec_data  (dec_data)
    );

    // Combinational, so the write commits on the edge after decode
    mmio_wr_data_map #(.DATA_WIDTH(`MMIO_DATA_WIDTH)) u_data_map
    (
        .byte_addr   (dec_addr),
        .byte_count  (dec_count),
        .payload_in  (dec_data),
        .payload_out (map_data),
        .byte_mask   (map_mask)
    );

    mmio_csr_file u_csr_file
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_err   (dec_err),
        .dec_idx   (dec_idx),
        .map_data  (map_data),
        .map_mask  (map_mask),
        .rd_req    (rd_req),
        .rd_idx    (rd_idx),
        .wr_ack    (wr_ack),
        .wr_err    (wr_err),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

endmodule

// ==== verification/tb_mmio_wr.sv ====
// Testbench for the MMIO write path with a stimulus table, reference model and response checks
`timescale 1ns/1ps
`include "mmio_defs.svh"

module tb_mmio_wr;

    localparam int MAX_ENT = 128;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_req;
    mmio_pkg::t_byte_addr  wr_addr;
    mmio_pkg::t_byte_count wr_count;
    mmio_pkg::t_payload    wr_data;
    logic                  rd_req;
    mmio_pkg::t_reg_idx    rd_idx;
    logic                  wr_ack;
    logic                  wr_err;
    logic                  rd_valid;
    mmio_pkg::t_payload    rd_data;

    // Stimulus table with one row per request and the expected outcome of each row
    logic                  t_is_wr [MAX_ENT];
    mmio_pkg::t_byte_addr  t_addr  [MAX_ENT];
    mmio_pkg::t_byte_count t_count [MAX_ENT];
    mmio_pkg::t_payload    t_data  [MAX_ENT];
    logic                  t_err   [MAX_ENT];
    mmio_pkg::t_payload    t_exp   [MAX_ENT];
    int                    t_gap   [MAX_ENT];
    int                    n_ent;
    int                    grp     [7];
    string                 names   [6];

    // Reference copy of the register file
    mmio_pkg::t_payload    model [`MMIO_NUM_REGS];

    // Responses still owed by the DUT and the cycle each one is due in
    int                    wr_due  [$];
    logic                  wr_bad  [$];
    int                    rd_due  [$];
    mmio_pkg::t_payload    rd_want [$];

    int cyc    = 0;
    int limit  = 0;
    int errors = 0;
    int checks = 0;

    mmio_wr_top u_dut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_count (wr_count),
        .wr_data  (wr_data),
        .rd_req   (rd_req),
        .rd_idx   (rd_idx),
        .wr_ack   (wr_ack),
        .wr_err   (wr_err),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Rising edges are counted here and the count also bounds the run
    always @(posedge clk)
    begin
        cyc = cyc + 1;
        if (limit > 0 && cyc >= limit)
        begin
            $display("Run timed out after %0d cycles while waiting for DUT responses", cyc);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Adds a write row and applies it to the model when it is legal
    task automatic write_entry(input logic [63:0] addr, input logic [11:0] count,
                               input logic [63:0] data, input int gap);
        logic               legal;
        mmio_pkg::t_reg_idx idx;
        // A dword write needs dword alignment and a qword write needs qword alignment
        legal = (count == 12'd4 || count == 12'd8) && (addr[1:0] == 2'b00)
                && !(count == 12'd8 && addr[2]) && (addr < 64'(`MMIO_WINDOW_BYTES));
        idx = addr[6:3];
        // Only the low 32 payload bits matter for a dword write whichever half it hits
        if (legal && count == 12'd8)
            model[idx] = data;
        else if (legal && addr[2])
            model[idx][63:32] = data[31:0];
        else if (legal)
            model[idx][31:0] = data[31:0];
        t_is_wr[n_ent] = 1'b1;
        t_addr[n_ent]  = addr;
        t_count[n_ent] = count;
        t_data[n_ent]  = data;
        t_err[n_ent]   = !legal;
        t_gap[n_ent]   = gap;
        n_ent++;
    endtask

    task automatic read_entry(input int idx);
        t_is_wr[n_ent] = 1'b0;
        t_addr[n_ent]  = 64'(idx);
        t_exp[n_ent]   = model[idx];
        t_gap[n_ent]   = 0;
        n_ent++;
    endtask

    task automatic build_table();
        logic [63:0] addr;
        logic [11:0] count;
        for (int r = 0; r < `MMIO_NUM_REGS; r++)
        begin
            model[r] = '0;
        end
        n_ent  = 0;
        grp[0] = n_ent;
        for (int r = 0; r < `MMIO_NUM_REGS; r++)
        begin
            read_entry(r);
        end
        // Full qword writes at the bottom, middle and top of the window
        grp[1] = n_ent;
        write_entry(64'h00, 12'd8, 64'h0123_4567_89ab_cdef, 2);
        write_entry(64'h38, 12'd8, 64'hfeed_face_cafe_beef, 2);
        write_entry(64'h78, 12'd8, 64'h8000_0000_0000_0001, 1);
        read_entry(0);
        read_entry(7);
        read_entry(15);
        // Dword writes into each half of register 2
        grp[2] = n_ent;
        write_entry(64'h10, 12'd8, 64'h1111_2222_3333_4444, 1);
        write_entry(64'h10, 12'd4, 64'h0000_0000_aaaa_5555, 1);
        read_entry(2);
        write_entry(64'h14, 12'd4, 64'hdead_0000_beef_7777, 1);
        read_entry(2);
        // Register 3 gets a known value and then every illegal form aims at it
        grp[3] = n_ent;
        write_entry(64'h18, 12'd8, 64'h0f0f_0f0f_f0f0_f0f0, 1);
        write_entry(64'h18, 12'd2, {$urandom, $urandom}, 1);
        write_entry(64'h18, 12'd16, {$urandom, $urandom}, 1);
        write_entry(64'h1a, 12'd4, {$urandom, $urandom}, 1);
        write_entry(64'h1c, 12'd8, {$urandom, $urandom}, 1);
        write_entry(64'h80, 12'd8, {$urandom, $urandom}, 1);
        write_entry(64'h1_0000_0018, 12'd4, {$urandom, $urandom}, 1);
        read_entry(3);
        read_entry(0);
        // Writes on consecutive cycles with four of them to register 5
        grp[4] = n_ent;
        write_entry(64'h28, 12'd8, 64'h5555_5555_5555_5555, 0);
        write_entry(64'h28, 12'd4, 64'h0000_0000_1234_5678, 0);
        write_entry(64'h2c, 12'd4, 64'h0000_0000_9abc_def0, 0);
        write_entry(64'h30, 12'd8, 64'h6666_7777_8888_9999, 0);
        write_entry(64'h28, 12'd4, 64'h0000_0000_0bad_f00d, 1);
        read_entry(5);
        read_entry(6);
        grp[5] = n_ent;
        for (int k = 0; k < 24; k++)
        begin
            // Half of the addresses are dword aligned and the rest may stray past the window
            if ($urandom % 2 == 0)
                addr = 64'(($urandom % 32) * 4);
            else
                addr = 64'($urandom % 160);
            case ($urandom % 6)
                0, 1:    count = 12'd4;
                2, 3:    count = 12'd8;
                4:       count = 12'd2;
                default: count = 12'd16;
            endcase
            write_entry(addr, count, {$urandom, $urandom}, (k == 23) ? 1 : int'($urandom % 2));
        end
        for (int r = 0; r < `MMIO_NUM_REGS; r++)
        begin
            read_entry(r);
        end
        grp[6] = n_ent;
    endtask

    // Called just after a falling edge when outputs have been stable since the rising edge
    task automatic observe();
        logic want_err;
        if (wr_due.size() > 0 && wr_due[0] < cyc)
        begin
            errors++;
            $display("Write outcome pulse never came, it was due in cycle %0d", wr_due[0]);
            void'(wr_due.pop_front());
            void'(wr_bad.pop_front());
        end
        if (rd_due.size() > 0 && rd_due[0] < cyc)
        begin
            errors++;
            $display("Read response never came, it was due in cycle %0d", rd_due[0]);
            void'(rd_due.pop_front());
            void'(rd_want.pop_front());
        end
        if (wr_ack || wr_err)
        begin
            if (wr_due.size() == 0)
            begin
                errors++;
                $display("Write outcome pulse at %0t with no write outstanding", $time);
            end
            else
            begin
                want_err = wr_bad.pop_front();
                check(64'(cyc), 64'(wr_due.pop_front()), "write outcome cycle");
                check(64'(wr_err), 64'(want_err), "write error pulse");
                check(64'(wr_ack), 64'(!want_err), "write ack pulse");
            end
        end
        if (rd_valid)
        begin
            if (rd_due.size() == 0)
            begin
                errors++;
                $display("Read valid pulse at %0t with no read outstanding", $time);
            end
            else
            begin
                check(64'(cyc), 64'(rd_due.pop_front()), "read response cycle");
                check(rd_data, rd_want.pop_front(), "read data");
            end
        end
    endtask

    task automatic run_range(input int first, input int last, input int num, input string name);
        int errs_before;
        errs_before = errors;
        for (int i = first; i <= last; i++)
        begin
            @(negedge clk);
            observe();
            wr_req = t_is_wr[i];
            rd_req = !t_is_wr[i];
            if (t_is_wr[i])
            begin
                wr_addr  = t_addr[i];
                wr_count = t_count[i];
                wr_data  = t_data[i];
                // Sampled and decoded at the next rising edge and committed one edge later
                wr_due.push_back(cyc + 2);
                wr_bad.push_back(t_err[i]);
            end
            else
            begin
                rd_idx = t_addr[i][3:0];
                rd_due.push_back(cyc + 1);
                rd_want.push_back(t_exp[i]);
            end
            for (int g = 0; g < t_gap[i]; g++)
            begin
                @(negedge clk);
                observe();
                wr_req = 1'b0;
                rd_req = 1'b0;
            end
        end
        // Drain the pipeline and then idle a little so stray pulses are caught
        while (wr_due.size() > 0 || rd_due.size() > 0)
        begin
            @(negedge clk);
            observe();
            wr_req = 1'b0;
            rd_req = 1'b0;
        end
        repeat (2)
        begin
            @(negedge clk);
            observe();
        end
        $display("Test %0d %s: %s with %0d errors", num, name,
                 (errors == errs_before) ? "passed" : "failed", errors - errs_before);
    endtask

    initial
    begin
        rst_n    = 1'b0;
        wr_req   = 1'b0;
        wr_addr  = '0;
        wr_count = '0;
        wr_data  = '0;
        rd_req   = 1'b0;
        rd_idx   = '0;
        names    = '{"reset state", "qword writes", "dword writes", "rejections",
                     "back-to-back writes", "random sequence"};
        void'($urandom(32'h9a0c));
        build_table();
        // Each row takes at most three cycles and the drains and reset fit in the margin
        limit = n_ent * 4 + 20;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < 6; t++)
        begin
            run_range(grp[t], grp[t+1] - 1, t + 1, names[t]);
        end
        $display("Tests run: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/mmio_pkg.sv
rtl/mmio_wr_decode.sv
mmio_wr_data/mmio_wr_data_map.sv
mmio_csr_file/mmio_csr_file.sv
rtl/mmio_wr_top.sv
verification/tb_mmio_wr.sv

// ==== Makefile ====
# Verilator build for the MMIO write path

VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       := tb_mmio_wr
RTL_TOP   := mmio_wr_top
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

# Lint the design on its own, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
